/* list.f */
+incdir+logic
logic/fpTypesPkg.sv
logic/busPkg.sv
logic/fpClassify.sv
logic/fpCompare.sv
logic/fcmpBusPort.sv
logic/fcmpResults.sv
logic/fcmpUnit.sv
testbench/fcmpUnit_checker.sv
testbench/fcmpUnit_tb.sv

/* testbench/fcmpUnit_tb.sv */
// testbench for the floating-point compare coprocessor
// table of directed and random rows applied over the Wishbone port
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_defines.svh"

module fcmpUnit_tb;
   import fpTypesPkg::*;
   import busPkg::*;

   // min/max of two NaNs, canonical or payload of X quietened
   localparam bit    ieeeNan = (`FCMP_IEEE_NAN != 0);
   localparam fpWord nan2D   = ieeeNan ? 64'h7ff8000000000123 : 64'h7ff8000000000000;

   logic       clk, rstN, cyc, stb, we;
   logic [3:0] sel;
   busAddr     adr;
   busData     datIn, datOut;
   logic       ack;

   // stimulus table, one entry per row in each queue
   string names[$];
   cmpOp  ops[$];
   fpFmt  fmts[$];
   fpWord xs[$], ys[$], fps[$];
   logic  ints[$], nvs[$];

   integer seed;
   int     cycles = 0;
   int     limit = 0;

   fcmpUnit UUT (.clk, .rstN, .cyc, .stb, .we, .adr, .datIn, .sel, .datOut, .ack);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // run bound from the table length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit)
         failRun("timeout, the bus sequence did not complete");
   end

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic checkWord(input string name, input fpWord exp, input fpWord act);
      if (act !== exp)
         failRun($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic checkInt(input string name, input intRes exp, input intRes act);
      if (act !== exp)
         failRun($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      if (act !== exp)
         failRun($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
   endtask

   ////////////////////////////////////////////////////////////
   // bus access
   ////////////////////////////////////////////////////////////

   function automatic busAddr wordAddr(input regIndex i);
      return {2'b00, i, 2'b00};
   endfunction

   task automatic busWrite(input busAddr a, input busData d);
      @(posedge clk);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= 1'b1;
      adr   <= a;
      datIn <= d;
      // ack seen on the edge after the slave raised it
      @(posedge clk);
      while (!ack) @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic busRead(input busAddr a, output busData d);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= 1'b0;
      adr <= a;
      @(posedge clk);
      while (!ack) @(posedge clk);
      d   = datOut;
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic readCheck(input string name, input busAddr a, input busData exp);
      busData d;
      busRead(a, d);
      checkInt(name, exp, d);
   endtask

   // operands first, the control write starts the compare
   task automatic runOp(input cmpOp op, input fpFmt f, input fpWord x, input fpWord y);
      busWrite(wordAddr(`REG_XLO), x[31:0]);
      busWrite(wordAddr(`REG_XHI), x[63:32]);
      busWrite(wordAddr(`REG_YLO), y[31:0]);
      busWrite(wordAddr(`REG_YHI), y[63:32]);
      busWrite(wordAddr(`REG_CTRL), {27'd0, f, 1'b0, op});
   endtask

   task automatic addRow(input string nm, input cmpOp op, input fpFmt f, input fpWord x,
         input fpWord y, input fpWord res, input logic iv, input logic nv);
      names.push_back(nm);
      ops.push_back(op);
      fmts.push_back(f);
      xs.push_back(x);
      ys.push_back(y);
      fps.push_back(res);
      ints.push_back(iv);
      nvs.push_back(nv);
   endtask

   // ordinary finite doubles, ordering taken from their real values
   task automatic refModel(input cmpOp op, input fpWord x, input fpWord y,
         output fpWord res, output logic iv);
      real rx, ry;
      rx  = $bitstoreal(x);
      ry  = $bitstoreal(y);
      res = '0;
      iv  = 1'b0;
      case (op)
         OP_MIN:  res = (rx < ry) ? x : y;
         OP_MAX:  res = (rx < ry) ? y : x;
         OP_EQ:   iv = (rx == ry);
         OP_LT:   iv = (rx < ry);
         default: iv = (rx <= ry);
      endcase
   endtask

   task automatic applyRow(input int i);
      busData lo, hi, iv, fl;
      runOp(ops[i], fmts[i], xs[i], ys[i]);
      busRead(wordAddr(`REG_RESLO), lo);
      busRead(wordAddr(`REG_RESHI), hi);
      busRead(wordAddr(`REG_INTRES), iv);
      checkWord(names[i], fps[i], {hi, lo});
      checkInt(names[i], intRes'(ints[i]), iv);
      busRead(wordAddr(`REG_FLAGS), fl);
      checkFlag(names[i], nvs[i], fl[0]);
      busWrite(wordAddr(`REG_FLAGS), 32'd1);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      fpWord x, y, r;
      logic  iv;
      cmpOp  opList[5];
      opList = '{OP_LT, OP_EQ, OP_LE, OP_MAX, OP_MIN};
      rstN   = 1'b0;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      adr    = '0;
      datIn  = '0;
      sel    = 4'hf;
      seed   = 32'h13db1ea4;

      // ordering, infinities and signed zeros
      addRow("lt_d", OP_LT, 1, 64'h3ff0000000000000, 64'h4000000000000000, 0, 1, 0);
      addRow("lt_d_neg", OP_LT, 1, 64'hc000000000000000, 64'hbff0000000000000, 0, 1, 0);
      addRow("le_d_neg", OP_LE, 1, 64'hbff0000000000000, 64'hc000000000000000, 0, 0, 0);
      addRow("eq_d_zero", OP_EQ, 1, 64'h8000000000000000, 64'h0, 0, 1, 0);
      addRow("lt_d_zero", OP_LT, 1, 64'h8000000000000000, 64'h0, 0, 0, 0);
      addRow("le_d_inf", OP_LE, 1, 64'h7ff0000000000000, 64'h7ff0000000000000, 0, 1, 0);
      addRow("lt_d_ninf", OP_LT, 1, 64'hfff0000000000000, 64'h3ff0000000000000, 0, 1, 0);
      addRow("eq_s", OP_EQ, 0, 64'hffffffff3f800000, 64'hffffffff3f800000, 0, 1, 0);
      addRow("lt_s", OP_LT, 0, 64'hffffffff40000000, 64'hffffffff3f800000, 0, 0, 0);
      addRow("le_s_zero", OP_LE, 0, 64'hffffffff80000000, 64'hffffffff00000000, 0, 1, 0);
      // unordered compares
      addRow("eq_d_qnan", OP_EQ, 1, 64'h7ff8000000000000, 64'h3ff0000000000000, 0, 0, 0);
      addRow("lt_d_qnan", OP_LT, 1, 64'h3ff0000000000000, 64'h7ff8000000000000, 0, 0, 1);
      addRow("le_s_qnan", OP_LE, 0, 64'hffffffff7fc00000, 64'hffffffff3f800000, 0, 0, 1);
      addRow("eq_d_snan", OP_EQ, 1, 64'h7ff0000000000001, 64'h3ff0000000000000, 0, 0, 1);
      addRow("eq_s_snan", OP_EQ, 0, 64'hffffffff7f800001, 64'hffffffff3f800000, 0, 0, 1);
      // min and max
      addRow("min_d_qnan", OP_MIN, 1, 64'h7ff8000000000000, 64'h4000000000000000,
         64'h4000000000000000, 0, 0);
      addRow("max_d_snan", OP_MAX, 1, 64'h3ff0000000000000, 64'h7ff0000000000001,
         64'h3ff0000000000000, 0, 1);
      addRow("min_d_2nan", OP_MIN, 1, 64'h7ff8000000000123, 64'hfff8000000000000, nan2D, 0, 0);
      addRow("min_d_zero", OP_MIN, 1, 64'h0, 64'h8000000000000000, 64'h8000000000000000, 0, 0);
      addRow("max_d_zero", OP_MAX, 1, 64'h8000000000000000, 64'h0, 64'h0, 0, 0);
      addRow("max_s", OP_MAX, 0, 64'hffffffff3f800000, 64'hffffffff40000000,
         64'hffffffff40000000, 0, 0);
      // badly boxed singles act as a quiet NaN
      addRow("min_s_unbox", OP_MIN, 0, 64'h000000003f800000, 64'hffffffff40000000,
         64'hffffffff40000000, 0, 0);
      addRow("lt_s_unbox", OP_LT, 0, 64'h000000003f800000, 64'hffffffff3f800000, 0, 0, 1);
      addRow("max_s_2nan", OP_MAX, 0, 64'h0, 64'h0000000100000000, 64'hffffffff7fc00000, 0, 0);
      addRow("min_s_snan", OP_MIN, 0, 64'hffffffff7f800001, 64'hffffffffbf800000,
         64'hffffffffbf800000, 0, 1);

      // random ordinary doubles
      for (int k = 0; k < 10; k++) begin
         x = {$random(seed), $random(seed)};
         y = {$random(seed), $random(seed)};
         // keep exponents off the inf/NaN code
         if (&x[62:52])
            x[62] = 1'b0;
         if (&y[62:52])
            y[62] = 1'b0;
         if (k % 3 == 1)
            y = x;
         refModel(opList[k % 5], x, y, r, iv);
         addRow($sformatf("rand%0d", k), opList[k % 5], 1, x, y, r, iv, 0);
      end
      limit = names.size() * 40 + 200;

      repeat (8) @(posedge clk);
      rstN <= 1'b1;

      foreach (names[i])
         applyRow(i);

      // flag held over a valid compare, cleared only by a one
      runOp(OP_LT, 1, 64'h7ff8000000000000, 64'h3ff0000000000000);
      runOp(OP_EQ, 1, 64'h3ff0000000000000, 64'h3ff0000000000000);
      readCheck("sticky_eq", wordAddr(`REG_INTRES), 32'd1);
      readCheck("sticky_set", wordAddr(`REG_FLAGS), 32'd1);
      busWrite(wordAddr(`REG_FLAGS), 32'd0);
      readCheck("sticky_zero_wr", wordAddr(`REG_FLAGS), 32'd1);
      busWrite(wordAddr(`REG_FLAGS), 32'd1);
      readCheck("sticky_clear", wordAddr(`REG_FLAGS), 32'd0);

      // register readback, undefined op gives zero results
      runOp(cmpOp'(3'b000), 1, 64'h0123456789abcdef, 64'hfedcba9876543210);
      readCheck("rd_xlo", wordAddr(`REG_XLO), 32'h89abcdef);
      readCheck("rd_xhi", wordAddr(`REG_XHI), 32'h01234567);
      readCheck("rd_ylo", wordAddr(`REG_YLO), 32'h76543210);
      readCheck("rd_yhi", wordAddr(`REG_YHI), 32'hfedcba98);
      readCheck("rd_ctrl", wordAddr(`REG_CTRL), 32'h10);
      readCheck("rd_reslo", wordAddr(`REG_RESLO), 32'd0);
      readCheck("rd_intres", wordAddr(`REG_INTRES), 32'd0);
      // unmapped words and addresses
      busWrite(wordAddr(4'd12), 32'hdeadbeef);
      // high address aliases word 0 in its low bits
      busWrite(8'h40, 32'hdeadbeef);
      readCheck("rd_unmap12", wordAddr(4'd12), 32'd0);
      readCheck("rd_unmap9", wordAddr(4'd9), 32'd0);
      readCheck("rd_high_adr", 8'h40, 32'd0);
      readCheck("rd_xlo_kept", wordAddr(`REG_XLO), 32'h89abcdef);

      @(posedge clk);
      if (UUT.busPort.busChecks.failCount == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         failRun("bus protocol assertion failed during the run");
      end
   end

endmodule

`default_nettype wire

/* testbench/fcmpUnit_checker.sv */
// Wishbone protocol checks for the compare unit's slave port
// bound into fcmpBusPort
`timescale 1ns/1ps
`default_nettype none

module fcmpUnit_checker (
   input logic           clk,
   input logic           rstN,
   input logic           cyc,
   input logic           stb,
   input logic           ack,
   input busPkg::busData datOut
);

   // failed assertions, read by the testbench at the end
   int failCount = 0;

   // ack answers a strobe inside an open cycle
   ackNeedsStrobe: assert property (@(posedge clk) disable iff (!rstN) ack |-> (cyc && stb))
      else begin
         failCount++;
         $error("ack high without cyc and stb");
      end

   // single-cycle acknowledge
   ackOneCycle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
      else begin
         failCount++;
         $error("ack high on two cycles in a row");
      end

   ackLowInReset: assert property (@(posedge clk) !rstN |-> !ack)
      else begin
         failCount++;
         $error("ack high while reset is asserted");
      end

   // read data fully driven while acknowledged
   datOutKnown: assert property (@(posedge clk) disable iff (!rstN) ack |-> !$isunknown(datOut))
      else begin
         failCount++;
         $error("datOut has unknown bits while ack is high");
      end

endmodule

bind fcmpBusPort fcmpUnit_checker busChecks (.clk, .rstN, .cyc, .stb, .ack, .datOut);

`default_nettype wire

/* logic/fcmpUnit.sv */
// floating-point compare coprocessor top
// Wishbone slave, two operand classifiers, comparator and result registers
`timescale 1ns/1ps
`default_nettype none

module fcmpUnit (
   input  logic           clk,
   input  logic           rstN,
   input  logic           cyc,
   input  logic           stb,
   input  logic           we,
   input  busPkg::busAddr adr,
   input  busPkg::busData datIn,
   // byte selects, only full-word access is supported
   input  logic [3:0]     sel,
   output busPkg::busData datOut,
   output logic           ack
);
   import fpTypesPkg::*;

   fpWord   xWord, yWord;
   cmpOp    opReg;
   fpFmt    fmtReg;
   logic    cmdStrobe, flagClear;
   fpWord   resWord;
   intRes   intWord;
   logic    flagNV;
   logic    xSgn, ySgn;
   expField xExp, yExp;
   manField xMan, yMan;
   logic    xZero, yZero, xNaN, yNaN, xSNaN, ySNaN;
   fpWord   cmpFpRes;
   intRes   cmpIntRes;
   logic    cmpInvalid;

   fcmpBusPort busPort (.clk, .rstN, .cyc, .stb, .we, .adr, .datIn, .resWord, .intWord,
      .flagNV, .datOut, .ack, .xWord, .yWord, .opReg, .fmtReg, .cmdStrobe, .flagClear);

   // one classifier per operand
   fpClassify classX (.word(xWord), .fmt(fmtReg), .sgn(xSgn), .expo(xExp), .man(xMan),
      .isZero(xZero), .isNaN(xNaN), .isSNaN(xSNaN));
   fpClassify classY (.word(yWord), .fmt(fmtReg), .sgn(ySgn), .expo(yExp), .man(yMan),
      .isZero(yZero), .isNaN(yNaN), .isSNaN(ySNaN));

   // combinational compare on the held operands
   fpCompare compare (.op(opReg), .fmt(fmtReg), .xSgn, .ySgn, .xExp, .yExp, .xMan, .yMan,
      .xZero, .yZero, .xNaN, .yNaN, .xSNaN, .ySNaN, .xWord, .yWord,
      .fpRes(cmpFpRes), .intOut(cmpIntRes), .invalid(cmpInvalid));

   fcmpResults results (.clk, .rstN, .cmdStrobe, .flagClear, .fpRes(cmpFpRes),
      .intOut(cmpIntRes), .invalid(cmpInvalid), .resWord, .intWord, .flagNV);

endmodule

`default_nettype wire

/* logic/fcmpResults.sv */
// result registers of the compare unit
// capture after each command, sticky invalid flag cleared by write-one
`timescale 1ns/1ps
`default_nettype none

module fcmpResults (
   input  logic                clk,
   input  logic                rstN,
   input  logic                cmdStrobe,
   input  logic                flagClear,
   input  fpTypesPkg::fpWord   fpRes,
   input  fpTypesPkg::intRes   intOut,
   input  logic                invalid,
   output fpTypesPkg::fpWord   resWord,
   output fpTypesPkg::intRes   intWord,
   output logic                flagNV
);

   ////////////////////////////////////////////////////////////
   // result capture, one cycle after the control write
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resWord <= '0;
         intWord <= '0;
      end else if (cmdStrobe) begin
         // operands are stable, comparator output settled
         resWord <= fpRes;
         intWord <= intOut;
      end
   end

   ////////////////////////////////////////////////////////////
   // sticky invalid flag
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         flagNV <= 1'b0;
      end else if (cmdStrobe & invalid) begin
         // a new invalid wins over a clear on the same edge
         flagNV <= 1'b1;
      end else if (flagClear) begin
         flagNV <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* logic/fcmpBusPort.sv */
// Wishbone classic slave for the compare unit
// operand and control registers, registered acknowledge and read-back multiplexer
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_defines.svh"

module fcmpBusPort (
   input  logic                clk,
   input  logic                rstN,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  busPkg::busAddr      adr,
   input  busPkg::busData      datIn,
   input  fpTypesPkg::fpWord   resWord,
   input  fpTypesPkg::intRes   intWord,
   input  logic                flagNV,
   output busPkg::busData      datOut,
   output logic                ack,
   output fpTypesPkg::fpWord   xWord,
   output fpTypesPkg::fpWord   yWord,
   output fpTypesPkg::cmpOp    opReg,
   output fpTypesPkg::fpFmt    fmtReg,
   output logic                cmdStrobe,
   output logic                flagClear
);
   import busPkg::*;
   import fpTypesPkg::*;

   regIndex idx;
   logic    inRange;
   logic    access;
   logic    wrEn;
   busData  rdData;

   // word index, upper address bits must be clear
   assign idx     = adr[5:2];
   assign inRange = (adr[7:6] == 2'b00);

   // new access when the master strobes and no ack is out
   assign access = cyc & stb & ~ack;
   assign wrEn   = access & we & inRange;

   ////////////////////////////////////////////////////////////
   // acknowledge, one cycle, no wait states
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   ////////////////////////////////////////////////////////////
   // register writes, taken on the edge raising ack
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         xWord     <= '0;
         yWord     <= '0;
         opReg     <= cmpOp'(3'b000);
         fmtReg    <= 1'b0;
         cmdStrobe <= 1'b0;
      end else begin
         // command pulse follows every control write
         cmdStrobe <= wrEn & (idx == `REG_CTRL);
         if (wrEn) begin
            case (idx)
               `REG_XLO: xWord[`XLEN-1:0]     <= datIn;
               `REG_XHI: xWord[`FLEN-1:`XLEN] <= datIn;
               `REG_YLO: yWord[`XLEN-1:0]     <= datIn;
               `REG_YHI: yWord[`FLEN-1:`XLEN] <= datIn;
               `REG_CTRL: begin
                  // op in 2:0, format in 4
                  opReg  <= cmpOp'(datIn[2:0]);
                  fmtReg <= datIn[4];
               end
               // results and unmapped words ignore writes
               default: ;
            endcase
         end
      end
   end

   // write one to bit 0 clears the sticky flag
   assign flagClear = wrEn & (idx == `REG_FLAGS) & datIn[0];

   // read-back select
   always_comb begin
      rdData = '0;
      if (inRange) begin
         case (idx)
            `REG_XLO:    rdData = xWord[`XLEN-1:0];
            `REG_XHI:    rdData = xWord[`FLEN-1:`XLEN];
            `REG_YLO:    rdData = yWord[`XLEN-1:0];
            `REG_YHI:    rdData = yWord[`FLEN-1:`XLEN];
            `REG_CTRL:   rdData = {{(`XLEN-5){1'b0}}, fmtReg, 1'b0, opReg};
            `REG_RESLO:  rdData = resWord[`XLEN-1:0];
            `REG_RESHI:  rdData = resWord[`FLEN-1:`XLEN];
            `REG_INTRES: rdData = intWord;
            `REG_FLAGS:  rdData = {{(`XLEN-1){1'b0}}, flagNV};
            default:     rdData = '0;
         endcase
      end
   end

   // read data registered with ack, holds between reads
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         datOut <= '0;
      end else if (access & ~we) begin
         datOut <= rdData;
      end
   end

endmodule

`default_nettype wire

/* logic/fpCompare.sv */
// comparison unit
// min/max result, integer compare result and invalid flag from two classified operands
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_defines.svh"

module fpCompare (
   input  fpTypesPkg::cmpOp    op,
   input  fpTypesPkg::fpFmt    fmt,
   input  logic                xSgn,
   input  logic                ySgn,
   input  fpTypesPkg::expField xExp,
   input  fpTypesPkg::expField yExp,
   input  fpTypesPkg::manField xMan,
   input  fpTypesPkg::manField yMan,
   input  logic                xZero,
   input  logic                yZero,
   input  logic                xNaN,
   input  logic                yNaN,
   input  logic                xSNaN,
   input  logic                ySNaN,
   input  fpTypesPkg::fpWord   xWord,
   input  fpTypesPkg::fpWord   yWord,
   output fpTypesPkg::fpWord   fpRes,
   output fpTypesPkg::intRes   intOut,
   output logic                invalid
);
   import fpTypesPkg::*;

   localparam bit useIeeeNan = (`FCMP_IEEE_NAN != 0);

   logic  ltAbs;
   logic  lt;
   logic  eq;
   logic  bothZero;
   logic  eitherNaN;
   logic  eitherSNaN;
   fpWord nanRes;
   fpWord minRes;
   fpWord maxRes;

   // magnitude order, exponent over significand, as unsigned integers
   assign ltAbs = {xExp, xMan} < {yExp, yMan};
   // equal bit patterns, so -0 and +0 differ here
   assign eq    = (xWord == yWord);
   // sign decides first, two negatives reverse the magnitude order
   assign lt    = (xSgn & ~ySgn) | (xSgn & ySgn & ~ltAbs & ~eq) | (~xSgn & ~ySgn & ltAbs);

   assign bothZero   = xZero & yZero;
   assign eitherNaN  = xNaN | yNaN;
   assign eitherSNaN = xSNaN | ySNaN;

   ////////////////////////////////////////////////////////////
   // NaN result for min/max of two NaNs
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (fmt) begin
         if (useIeeeNan)
            nanRes = {xSgn, {`NE{1'b1}}, 1'b1, xMan[`NF-2:0]};
         else
            nanRes = {1'b0, {`NE{1'b1}}, 1'b1, {(`NF-1){1'b0}}};
      end else begin
         // single NaN goes back NaN-boxed
         if (useIeeeNan)
            nanRes = {{(`FLEN-`LEN1){1'b1}}, xSgn, {`NE1{1'b1}}, 1'b1, xMan[`NF1-2:0]};
         else
            nanRes = {{(`FLEN-`LEN1){1'b1}}, 1'b0, {`NE1{1'b1}}, 1'b1, {(`NF1-1){1'b0}}};
      end
   end

   // one NaN gives the other operand, -0 orders below +0
   assign minRes = xNaN ? (yNaN ? nanRes : yWord) : (yNaN ? xWord : (lt ? xWord : yWord));
   assign maxRes = xNaN ? (yNaN ? nanRes : yWord) : (yNaN ? xWord : (lt ? yWord : xWord));

   ////////////////////////////////////////////////////////////
   // op select, unordered compares return 0
   ////////////////////////////////////////////////////////////

   always_comb begin
      fpRes   = '0;
      intOut  = '0;
      invalid = 1'b0;
      case (op)
         OP_MIN: begin
            fpRes   = minRes;
            invalid = eitherSNaN;
         end
         OP_MAX: begin
            fpRes   = maxRes;
            invalid = eitherSNaN;
         end
         OP_EQ: begin
            // quiet compare, only sNaN is invalid
            intOut  = {{(`XLEN-1){1'b0}}, (eq | bothZero) & ~eitherNaN};
            invalid = eitherSNaN;
         end
         OP_LT: begin
            intOut  = {{(`XLEN-1){1'b0}}, lt & ~bothZero & ~eitherNaN};
            invalid = eitherNaN;
         end
         OP_LE: begin
            intOut  = {{(`XLEN-1){1'b0}}, (lt | eq | bothZero) & ~eitherNaN};
            invalid = eitherNaN;
         end
         // undefined codes leave everything zero
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* logic/fpClassify.sv */
// operand classifier
// splits one 64-bit register by format into sign, exponent, significand and class bits
`timescale 1ns/1ps
`default_nettype none

`include "fcmp_defines.svh"

module fpClassify (
   input  fpTypesPkg::fpWord   word,
   input  fpTypesPkg::fpFmt    fmt,
   output logic                sgn,
   output fpTypesPkg::expField expo,
   output fpTypesPkg::manField man,
   output logic                isZero,
   output logic                isNaN,
   output logic                isSNaN
);
   import fpTypesPkg::*;

   // canonical quiet single NaN, stands in for a badly boxed operand
   localparam logic [`LEN1-1:0] canonSingle = {1'b0, {`NE1{1'b1}}, 1'b1, {(`NF1-1){1'b0}}};

   logic                boxed;
   logic [`LEN1-1:0]    sWord;
   logic [`NE1-1:0]     sExp;
   logic [`NF1-1:0]     sFrac;
   logic [`NE-1:0]      dExp;
   logic [`NF-1:0]      dFrac;
   logic                expMax;
   logic                fracZero;
   logic                fracMsb;

   // single must have the upper word all ones
   assign boxed = &word[`FLEN-1:`LEN1];
   assign sWord = boxed ? word[`LEN1-1:0] : canonSingle;

   // raw fields of both formats
   assign sExp  = sWord[`LEN1-2:`NF1];
   assign sFrac = sWord[`NF1-1:0];
   assign dExp  = word[`FLEN-2:`NF];
   assign dFrac = word[`NF-1:0];

   always_comb begin
      if (fmt) begin
         sgn      = word[`FLEN-1];
         expo     = dExp;
         // hidden bit is set for any nonzero exponent
         man      = {|dExp, dFrac};
         expMax   = &dExp;
         fracZero = ~|dFrac;
         fracMsb  = dFrac[`NF-1];
      end else begin
         sgn      = sWord[`LEN1-1];
         // single fields sit right-aligned in the wider fields
         expo     = {{(`NE-`NE1){1'b0}}, sExp};
         man      = {{(`NF-`NF1){1'b0}}, |sExp, sFrac};
         expMax   = &sExp;
         fracZero = ~|sFrac;
         fracMsb  = sFrac[`NF1-1];
      end
   end

   // zero has both exponent and fraction clear
   assign isZero = (expo == '0) & fracZero;
   // NaN is a maximal exponent with a nonzero fraction
   assign isNaN  = expMax & ~fracZero;
   // signaling when the quiet bit is clear
   assign isSNaN = isNaN & ~fracMsb;

endmodule

`default_nettype wire

/* logic/busPkg.sv */
// Wishbone slave port types
// data, byte address and register word index
`default_nettype none

`include "fcmp_defines.svh"

package busPkg;

   // bus data, same width as the integer result
   typedef logic [`XLEN-1:0] busData;

   // byte address seen by the slave
   typedef logic [7:0] busAddr;

   // word index decoded from adr[5:2]
   typedef logic [3:0] regIndex;

endpackage

`default_nettype wire

/* logic/fpTypesPkg.sv */
// floating-point field types and compare operation codes
// shared by the classifier, comparator and result registers
`default_nettype none

`include "fcmp_defines.svh"

package fpTypesPkg;

   // full operand or min/max result, single values NaN-boxed
   typedef logic [`FLEN-1:0] fpWord;

   // exponent, single exponents zero-extended on the left
   typedef logic [`NE-1:0] expField;

   // significand with leading bit, single right-aligned
   typedef logic [`NF:0] manField;

   // integer compare result written to rd
   typedef logic [`XLEN-1:0] intRes;

   // precision select, 1 double, 0 single
   typedef logic fpFmt;

   // operation codes as carried in the control register
   typedef enum logic [2:0] {
      OP_LT  = 3'b001,
      OP_EQ  = 3'b010,
      OP_LE  = 3'b011,
      OP_MAX = 3'b101,
      OP_MIN = 3'b110
   } cmpOp;

endpackage

`default_nettype wire

/* logic/fcmp_defines.svh */
// floating-point compare coprocessor parameters
// widths, register map and NaN result policy
`ifndef FCMP_DEFINES_SVH
`define FCMP_DEFINES_SVH

// operand register and integer/bus widths
`define FLEN 64
`define XLEN 32

// double and single field widths
`define NE   11
`define NF   52
`define NE1  8
`define NF1  23
`define LEN1 32

// 0 gives the RISC-V canonical NaN, 1 passes X's payload through quietened
`define FCMP_IEEE_NAN 0

// register map, word index
`define REG_XLO    4'd0
`define REG_XHI    4'd1
`define REG_YLO    4'd2
`define REG_YHI    4'd3
`define REG_CTRL   4'd4
`define REG_RESLO  4'd5
`define REG_RESHI  4'd6
`define REG_INTRES 4'd7
`define REG_FLAGS  4'd8

`endif
